//--- source/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [15:0] immT;
    typedef logic [4:0]  excCodeT;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_LUI,
        ALU_SLL,
        ALU_SRA,
        ALU_SRL,
        ALU_LT,
        ALU_LTU,
        ALU_NONE
    } aluOpT;

    typedef enum logic [2:0] {
        JUDGE_EQ,
        JUDGE_NE,
        JUDGE_GTZ,
        JUDGE_LEZ,
        JUDGE_GEZ,
        JUDGE_LTZ,
        JUDGE_NONE
    } judgeOpT;

    localparam excCodeT EXC_NONE    = 5'd0;
    localparam excCodeT EXC_SYSCALL = 5'd8;
    localparam excCodeT EXC_BP      = 5'd9;
    localparam excCodeT EXC_RI      = 5'd10;
    localparam excCodeT EXC_OV      = 5'd12;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // REGIMM rt field
    localparam regAddrT RT_BLTZ = 5'h00;
    localparam regAddrT RT_BGEZ = 5'h01;

    // SPECIAL function field
    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_SRL     = 6'h02;
    localparam logic [5:0] FN_SRA     = 6'h03;
    localparam logic [5:0] FN_SLLV    = 6'h04;
    localparam logic [5:0] FN_SRLV    = 6'h06;
    localparam logic [5:0] FN_SRAV    = 6'h07;
    localparam logic [5:0] FN_MOVZ    = 6'h0a;
    localparam logic [5:0] FN_MOVN    = 6'h0b;
    localparam logic [5:0] FN_SYSCALL = 6'h0c;
    localparam logic [5:0] FN_BREAK   = 6'h0d;
    localparam logic [5:0] FN_ADD     = 6'h20;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUB     = 6'h22;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_NOR     = 6'h27;
    localparam logic [5:0] FN_SLT     = 6'h2a;
    localparam logic [5:0] FN_SLTU    = 6'h2b;

endpackage

//--- source/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf import mipsPkg::*; ();

    logic    valid;
    aluOpT   aluOp;
    judgeOpT judgeOp;
    logic    useImm;
    logic    shiftByShamt;
    logic    isBranch;
    logic    isMove;
    logic    signedOv;
    logic    regWrite;
    regAddrT dst;
    regAddrT rs;
    regAddrT rt;
    wordT    rsVal;
    wordT    rtVal;
    // Already sign or zero extended
    wordT    imm;
    logic [4:0] shamt;
    logic    exc;
    excCodeT excCode;

    modport source (
        output valid, aluOp, judgeOp, useImm, shiftByShamt, isBranch, isMove,
        output signedOv, regWrite, dst, rs, rt, rsVal, rtVal, imm, shamt, exc, excCode
    );

    modport sink (
        input valid, aluOp, judgeOp, useImm, shiftByShamt, isBranch, isMove,
        input signedOv, regWrite, dst, rs, rt, rsVal, rtVal, imm, shamt, exc, excCode
    );

endinterface

//--- source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import mipsPkg::*; (
    input  wordT    inst,
    output aluOpT   aluOp,
    output judgeOpT judgeOp,
    output logic    useImm,
    output logic    immSext,
    output logic    shiftByShamt,
    output logic    isBranch,
    output logic    isMove,
    output logic    signedOv,
    output logic    regWrite,
    output logic    rdIsDst,
    output logic    exc,
    output excCodeT excCode
);

    logic [5:0] op;
    logic [5:0] fn;
    regAddrT    rsField;
    regAddrT    rtField;
    logic [4:0] sa;
    logic       rType;
    logic       unknown;

    logic isAdd, isAddu, isSub, isSubu;
    logic isAnd, isOr, isXor, isNor;
    logic isSlt, isSltu;
    logic isSll, isSra, isSrl, isSllv, isSrav, isSrlv;
    logic isMovz, isMovn, isSyscall, isBreak;
    logic isAddi, isAddiu, isSlti, isSltiu;
    logic isAndi, isOri, isXori, isLui;
    logic isBeq, isBne, isBlez, isBgtz, isBltz, isBgez;

    assign op      = inst[31:26];
    assign rsField = inst[25:21];
    assign rtField = inst[20:16];
    assign sa      = inst[10:6];
    assign fn      = inst[5:0];
    assign rType   = (op == OP_SPECIAL);

    // R-type ALU ops need a zero shamt field
    assign isAdd  = rType && sa == 0 && fn == FN_ADD;
    assign isAddu = rType && sa == 0 && fn == FN_ADDU;
    assign isSub  = rType && sa == 0 && fn == FN_SUB;
    assign isSubu = rType && sa == 0 && fn == FN_SUBU;
    assign isAnd  = rType && sa == 0 && fn == FN_AND;
    assign isOr   = rType && sa == 0 && fn == FN_OR;
    assign isXor  = rType && sa == 0 && fn == FN_XOR;
    assign isNor  = rType && sa == 0 && fn == FN_NOR;
    assign isSlt  = rType && sa == 0 && fn == FN_SLT;
    assign isSltu = rType && sa == 0 && fn == FN_SLTU;
    assign isMovz = rType && sa == 0 && fn == FN_MOVZ;
    assign isMovn = rType && sa == 0 && fn == FN_MOVN;

    // Immediate shifts keep rs zero, register shifts keep shamt zero
    assign isSll  = rType && rsField == 0 && fn == FN_SLL;
    assign isSra  = rType && rsField == 0 && fn == FN_SRA;
    assign isSrl  = rType && rsField == 0 && fn == FN_SRL;
    assign isSllv = rType && sa == 0 && fn == FN_SLLV;
    assign isSrav = rType && sa == 0 && fn == FN_SRAV;
    assign isSrlv = rType && sa == 0 && fn == FN_SRLV;

    assign isSyscall = rType && fn == FN_SYSCALL;
    assign isBreak   = rType && fn == FN_BREAK;

    assign isAddi  = (op == OP_ADDI);
    assign isAddiu = (op == OP_ADDIU);
    assign isSlti  = (op == OP_SLTI);
    assign isSltiu = (op == OP_SLTIU);
    assign isAndi  = (op == OP_ANDI);
    assign isOri   = (op == OP_ORI);
    assign isXori  = (op == OP_XORI);
    assign isLui   = (op == OP_LUI) && rsField == 0;

    assign isBeq  = (op == OP_BEQ);
    assign isBne  = (op == OP_BNE);
    assign isBlez = (op == OP_BLEZ) && rtField == 0;
    assign isBgtz = (op == OP_BGTZ) && rtField == 0;
    assign isBltz = (op == OP_REGIMM) && rtField == RT_BLTZ;
    assign isBgez = (op == OP_REGIMM) && rtField == RT_BGEZ;

    assign unknown = ~(
        isAdd | isAddu | isSub | isSubu | isAnd | isOr | isXor | isNor |
        isSlt | isSltu | isSll | isSra | isSrl | isSllv | isSrav | isSrlv |
        isMovz | isMovn | isSyscall | isBreak |
        isAddi | isAddiu | isSlti | isSltiu | isAndi | isOri | isXori | isLui |
        isBeq | isBne | isBlez | isBgtz | isBltz | isBgez
    );

    always_comb begin
        aluOp        = ALU_NONE;
        judgeOp      = JUDGE_NONE;
        useImm       = 1'b0;
        immSext      = 1'b0;
        shiftByShamt = 1'b0;
        isBranch     = 1'b0;
        isMove       = 1'b0;
        signedOv     = 1'b0;
        regWrite     = 1'b0;
        rdIsDst      = 1'b0;
        if (!unknown) begin
            if (isAdd | isAddu | isAddi | isAddiu)     aluOp = ALU_ADD;
            else if (isSub | isSubu)                   aluOp = ALU_SUB;
            else if (isAnd | isAndi)                   aluOp = ALU_AND;
            else if (isOr | isOri)                     aluOp = ALU_OR;
            else if (isNor)                            aluOp = ALU_NOR;
            else if (isXor | isXori)                   aluOp = ALU_XOR;
            else if (isLui)                            aluOp = ALU_LUI;
            else if (isSll | isSllv)                   aluOp = ALU_SLL;
            else if (isSra | isSrav)                   aluOp = ALU_SRA;
            else if (isSrl | isSrlv)                   aluOp = ALU_SRL;
            else if (isSlt | isSlti)                   aluOp = ALU_LT;
            else if (isSltu | isSltiu)                 aluOp = ALU_LTU;

            if (isBeq | isMovz)      judgeOp = JUDGE_EQ;
            else if (isBne | isMovn) judgeOp = JUDGE_NE;
            else if (isBgtz)         judgeOp = JUDGE_GTZ;
            else if (isBlez)         judgeOp = JUDGE_LEZ;
            else if (isBgez)         judgeOp = JUDGE_GEZ;
            else if (isBltz)         judgeOp = JUDGE_LTZ;

            useImm       = isAddi | isAddiu | isSlti | isSltiu | isAndi | isOri | isXori | isLui;
            immSext      = isAddi | isAddiu | isSlti | isSltiu;
            shiftByShamt = isSll | isSra | isSrl;
            isBranch     = isBeq | isBne | isBlez | isBgtz | isBltz | isBgez;
            isMove       = isMovz | isMovn;
            signedOv     = isAdd | isAddi | isSub;
            rdIsDst      = rType & ~isSyscall & ~isBreak;
            regWrite     = (rType & ~isSyscall & ~isBreak) | useImm;
        end
    end

    // RI first, then SYSCALL, then BREAK
    assign exc     = unknown | isSyscall | isBreak;
    assign excCode = unknown   ? EXC_RI :
                     isSyscall ? EXC_SYSCALL :
                     isBreak   ? EXC_BP : EXC_NONE;

endmodule

//--- source/regFile.sv
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT rs,
    input  regAddrT rt,
    output wordT    rsVal,
    output wordT    rtVal,
    input  logic    writeEn,
    input  regAddrT writeAddr,
    input  wordT    writeData
);

    // Register zero has no storage
    wordT regs [1:31];

    logic writeLive;

    assign writeLive = writeEn && writeAddr != '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Write-through so a read at the write-back edge sees the new value
    assign rsVal = (rs == '0) ? '0 :
                   (writeLive && writeAddr == rs) ? writeData : regs[rs];
    assign rtVal = (rt == '0) ? '0 :
                   (writeLive && writeAddr == rt) ? writeData : regs[rt];

    zeroReadsZero: assert property (
        @(posedge clk) disable iff (!rstN)
        rs == '0 |-> rsVal == '0
    );

endmodule

//--- source/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import mipsPkg::*; (
    input  aluOpT      op,
    input  wordT       a,
    input  wordT       b,
    input  logic [4:0] shamt,
    output wordT       result,
    output logic       overflow
);

    wordT       sum;
    wordT       diff;
    logic [4:0] shiftAmt;
    logic       addOv;
    logic       subOv;

    assign sum  = a + b;
    assign diff = a - b;

    // Immediate shifts come with a zero, register shifts with a zero shamt
    assign shiftAmt = shamt | a[4:0];

    // Signed overflow when the sign of the result disagrees with the operands
    assign addOv = (a[31] == b[31]) && (sum[31] != a[31]);
    assign subOv = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb begin
        case (op)
            ALU_ADD: result = sum;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_NOR: result = ~(a | b);
            ALU_XOR: result = a ^ b;
            ALU_LUI: result = {b[15:0], 16'h0000};
            ALU_SLL: result = b << shiftAmt;
            ALU_SRA: result = wordT'($signed(b) >>> shiftAmt);
            ALU_SRL: result = b >> shiftAmt;
            ALU_LT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_LTU: result = {31'b0, a < b};
            default: result = '0;
        endcase
    end

    always_comb begin
        case (op)
            ALU_ADD: overflow = addOv;
            ALU_SUB: overflow = subOv;
            default: overflow = 1'b0;
        endcase
    end

endmodule

//--- source/execStage.sv
`timescale 1ns/1ps

module execStage import mipsPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       stall,
    decodeIf.sink      dec,
    output logic       resValid,
    output logic       resWrite,
    output logic       resBranch,
    output logic       resTaken,
    output logic       resExc,
    output regAddrT    resDst,
    output wordT       resData,
    output excCodeT    resExcCode
);

    wordT       rsFwd;
    wordT       rtFwd;
    wordT       aluB;
    wordT       aluResult;
    logic       aluOverflow;
    logic [4:0] aluShamt;
    wordT       judgeA;
    wordT       judgeB;
    logic       judge;
    logic       ovExc;
    logic       anyExc;
    logic       writeOk;

    // Older result not yet in the register file
    assign rsFwd = (resValid && resWrite && resDst != '0 && resDst == dec.rs) ? resData : dec.rsVal;
    assign rtFwd = (resValid && resWrite && resDst != '0 && resDst == dec.rt) ? resData : dec.rtVal;

    assign aluB     = dec.useImm ? dec.imm : rtFwd;
    assign aluShamt = dec.shiftByShamt ? dec.shamt : 5'd0;

    aluUnit alu (
        .op       (dec.aluOp),
        .a        (rsFwd),
        .b        (aluB),
        .shamt    (aluShamt),
        .result   (aluResult),
        .overflow (aluOverflow)
    );

    // Moves test rt against zero, branches compare rs with rt
    assign judgeA = dec.isMove ? rtFwd : rsFwd;
    assign judgeB = dec.isMove ? '0 : rtFwd;

    always_comb begin
        case (dec.judgeOp)
            JUDGE_EQ:  judge = (judgeA == judgeB);
            JUDGE_NE:  judge = (judgeA != judgeB);
            JUDGE_GTZ: judge = ($signed(judgeA) > 0);
            JUDGE_LEZ: judge = ($signed(judgeA) <= 0);
            JUDGE_GEZ: judge = ~judgeA[31];
            JUDGE_LTZ: judge = judgeA[31];
            default:   judge = 1'b0;
        endcase
    end

    assign ovExc   = dec.signedOv && aluOverflow;
    assign anyExc  = dec.exc || ovExc;
    assign writeOk = dec.regWrite && !anyExc && !dec.isBranch && (!dec.isMove || judge);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid  <= 1'b0;
            resWrite  <= 1'b0;
            resExc    <= 1'b0;
            resBranch <= 1'b0;
            resTaken  <= 1'b0;
        end else if (!stall) begin
            resValid   <= dec.valid;
            resWrite   <= dec.valid && writeOk;
            resExc     <= dec.valid && anyExc;
            resBranch  <= dec.valid && dec.isBranch;
            resTaken   <= dec.valid && dec.isBranch && judge;
            resDst     <= dec.dst;
            resData    <= dec.isMove ? rsFwd : aluResult;
            resExcCode <= dec.exc ? dec.excCode : (ovExc ? EXC_OV : EXC_NONE);
        end
    end

    noWriteOnExc: assert property (
        @(posedge clk) disable iff (!rstN)
        !(resValid && resWrite && resExc)
    );

endmodule

//--- source/mipsSlice.sv
`timescale 1ns/1ps

module mipsSlice import mipsPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    instValid,
    output logic    instReady,
    input  wordT    inst,
    output logic    resValid,
    input  logic    resReady,
    output logic    resWrite,
    output regAddrT resDst,
    output wordT    resData,
    output logic    resBranch,
    output logic    resTaken,
    output logic    resExc,
    output excCodeT resExcCode
);

    aluOpT   aluOp;
    judgeOpT judgeOp;
    logic    useImm;
    logic    immSext;
    logic    shiftByShamt;
    logic    isBranch;
    logic    isMove;
    logic    signedOv;
    logic    regWrite;
    logic    rdIsDst;
    logic    exc;
    excCodeT excCode;
    wordT    rsVal;
    wordT    rtVal;
    immT     immField;
    logic    stall;

    decodeIf dec ();

    // Hold both stages while the output is blocked
    assign stall     = resValid && !resReady;
    assign instReady = !stall;
    assign immField  = inst[15:0];

    controlUnit ctrl (
        .inst         (inst),
        .aluOp        (aluOp),
        .judgeOp      (judgeOp),
        .useImm       (useImm),
        .immSext      (immSext),
        .shiftByShamt (shiftByShamt),
        .isBranch     (isBranch),
        .isMove       (isMove),
        .signedOv     (signedOv),
        .regWrite     (regWrite),
        .rdIsDst      (rdIsDst),
        .exc          (exc),
        .excCode      (excCode)
    );

    regFile rf (
        .clk       (clk),
        .rstN      (rstN),
        .rs        (inst[25:21]),
        .rt        (inst[20:16]),
        .rsVal     (rsVal),
        .rtVal     (rtVal),
        .writeEn   (resValid && resReady && resWrite),
        .writeAddr (resDst),
        .writeData (resData)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dec.valid <= 1'b0;
        end else if (!stall) begin
            dec.valid <= instValid;
        end
    end

    // Payload loads only on an accepted instruction
    always_ff @(posedge clk) begin
        if (instValid && instReady) begin
            dec.aluOp        <= aluOp;
            dec.judgeOp      <= judgeOp;
            dec.useImm       <= useImm;
            dec.shiftByShamt <= shiftByShamt;
            dec.isBranch     <= isBranch;
            dec.isMove       <= isMove;
            dec.signedOv     <= signedOv;
            dec.regWrite     <= regWrite;
            dec.dst          <= rdIsDst ? inst[15:11] : inst[20:16];
            dec.rs           <= inst[25:21];
            dec.rt           <= inst[20:16];
            dec.rsVal        <= rsVal;
            dec.rtVal        <= rtVal;
            dec.imm          <= immSext ? {{16{immField[15]}}, immField} : {16'h0000, immField};
            dec.shamt        <= inst[10:6];
            dec.exc          <= exc;
            dec.excCode      <= excCode;
        end
    end

    execStage ex (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall),
        .dec        (dec),
        .resValid   (resValid),
        .resWrite   (resWrite),
        .resBranch  (resBranch),
        .resTaken   (resTaken),
        .resExc     (resExc),
        .resDst     (resDst),
        .resData    (resData),
        .resExcCode (resExcCode)
    );

    instHeld: assert property (
        @(posedge clk) disable iff (!rstN)
        instValid && !instReady |=> instValid && $stable(inst)
    );

endmodule

//--- dv/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef struct packed {
    logic    write;
    regAddrT dst;
    wordT    data;
    logic    branch;
    logic    taken;
    logic    exc;
    excCodeT excCode;
} expResT;

// Architectural state in program order
wordT shadowRegs [0:31] = '{default: '0};

function automatic logic addOverflows(input wordT a, input wordT b, input logic subtract);
    logic [32:0] wide;
    wide = subtract ? {a[31], a} - {b[31], b} : {a[31], a} + {b[31], b};
    return wide[32] != wide[31];
endfunction

function automatic expResT predictResult(input wordT w);
    expResT     r;
    logic [5:0] op;
    logic [5:0] fn;
    regAddrT    rs;
    regAddrT    rt;
    logic [4:0] sa;
    wordT       a;
    wordT       b;
    wordT       se;
    wordT       ze;
    logic       known;
    logic       ov;
    op = w[31:26];
    fn = w[5:0];
    rs = w[25:21];
    rt = w[20:16];
    sa = w[10:6];
    a = shadowRegs[rs];
    b = shadowRegs[rt];
    se = {{16{w[15]}}, w[15:0]};
    ze = {16'h0000, w[15:0]};
    r = '0;
    r.write = 1'b1;
    r.dst = rt;
    known = 1'b1;
    ov = 1'b0;
    case (op)
        OP_SPECIAL: begin
            r.dst = w[15:11];
            // Immediate shifts need rs zero and the rest need shamt zero
            if (fn inside {FN_SLL, FN_SRL, FN_SRA}) begin
                known = (rs == '0);
            end else if (!(fn inside {FN_SYSCALL, FN_BREAK})) begin
                known = (sa == '0);
            end
            case (fn)
                FN_ADD: begin
                    r.data = a + b;
                    ov = addOverflows(a, b, 1'b0);
                end
                FN_ADDU: r.data = a + b;
                FN_SUB: begin
                    r.data = a - b;
                    ov = addOverflows(a, b, 1'b1);
                end
                FN_SUBU:    r.data = a - b;
                FN_AND:     r.data = a & b;
                FN_OR:      r.data = a | b;
                FN_XOR:     r.data = a ^ b;
                FN_NOR:     r.data = ~(a | b);
                FN_SLT:     r.data = wordT'($signed(a) < $signed(b));
                FN_SLTU:    r.data = wordT'(a < b);
                FN_SLL:     r.data = b << sa;
                FN_SRL:     r.data = b >> sa;
                FN_SRA:     r.data = wordT'($signed(b) >>> sa);
                FN_SLLV:    r.data = b << a[4:0];
                FN_SRLV:    r.data = b >> a[4:0];
                FN_SRAV:    r.data = wordT'($signed(b) >>> a[4:0]);
                FN_MOVZ: begin
                    r.data = a;
                    r.write = (b == '0);
                end
                FN_MOVN: begin
                    r.data = a;
                    r.write = (b != '0);
                end
                FN_SYSCALL: r.excCode = EXC_SYSCALL;
                FN_BREAK:   r.excCode = EXC_BP;
                default:    known = 1'b0;
            endcase
        end
        OP_ADDI: begin
            r.data = a + se;
            ov = addOverflows(a, se, 1'b0);
        end
        OP_ADDIU: r.data = a + se;
        OP_SLTI:  r.data = wordT'($signed(a) < $signed(se));
        OP_SLTIU: r.data = wordT'(a < se);
        OP_ANDI:  r.data = a & ze;
        OP_ORI:   r.data = a | ze;
        OP_XORI:  r.data = a ^ ze;
        OP_LUI: begin
            r.data = {w[15:0], 16'h0000};
            known = (rs == '0);
        end
        OP_BEQ: r.taken = (a == b);
        OP_BNE: r.taken = (a != b);
        OP_BLEZ: begin
            r.taken = ($signed(a) <= 0);
            known = (rt == '0);
        end
        OP_BGTZ: begin
            r.taken = ($signed(a) > 0);
            known = (rt == '0);
        end
        OP_REGIMM: begin
            r.taken = (rt == RT_BLTZ) ? a[31] : !a[31];
            known = (rt == RT_BLTZ) || (rt == RT_BGEZ);
        end
        default: known = 1'b0;
    endcase
    r.branch = (op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM}) && known;
    r.taken = r.taken && r.branch;
    if (!known) begin
        r.excCode = EXC_RI;
    end else if (ov) begin
        r.excCode = EXC_OV;
    end
    r.exc = (r.excCode != EXC_NONE);
    r.write = r.write && !r.exc && !r.branch;
    if (r.write && r.dst != '0) begin
        shadowRegs[r.dst] = r.data;
    end
    return r;
endfunction

`endif

//--- dv/mipsSliceTb.sv
`timescale 1ns/1ps

module mipsSliceTb import mipsPkg::*; ();

    localparam int numInsts = 2000;

    localparam logic [5:0] regFunctions [0:15] = '{
        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
        FN_SLT, FN_SLTU, FN_SLLV, FN_SRLV, FN_SRAV, FN_MOVZ, FN_MOVN, FN_ADD
    };
    localparam logic [5:0] immOpcodes [0:7] = '{
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI
    };
    localparam logic [5:0] branchOpcodes [0:4] = '{
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM
    };
    localparam logic [5:0] shiftFunctions [0:2] = '{FN_SLL, FN_SRL, FN_SRA};

    logic    clk = 1'b0;
    logic    rstN;
    logic    instValid;
    logic    instReady;
    wordT    inst;
    logic    resValid;
    logic    resReady;
    logic    resWrite;
    regAddrT resDst;
    wordT    resData;
    logic    resBranch;
    logic    resTaken;
    logic    resExc;
    excCodeT resExcCode;

    `include "tbModel.svh"

    expResT resultQueue [$];
    expResT head;
    logic   headValid = 1'b0;
    int     issued = 0;
    int     acceptCount = 0;
    int     doneCount = 0;

    always #2 clk = ~clk;

    mipsSlice uut (
        .clk        (clk),
        .rstN       (rstN),
        .instValid  (instValid),
        .instReady  (instReady),
        .inst       (inst),
        .resValid   (resValid),
        .resReady   (resReady),
        .resWrite   (resWrite),
        .resDst     (resDst),
        .resData    (resData),
        .resBranch  (resBranch),
        .resTaken   (resTaken),
        .resExc     (resExc),
        .resExcCode (resExcCode)
    );

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input wordT expected, input wordT actual);
        failRun($sformatf("ERR %s expected=%h got=%h", name, expected, actual));
    endtask

    // Small register range so back-to-back dependencies are common
    function automatic regAddrT pickReg();
        return regAddrT'($urandom % 4);
    endfunction

    function automatic wordT randomInst();
        logic [5:0]  op;
        logic [4:0]  sa;
        logic [15:0] imm;
        sa = 5'($urandom);
        imm = 16'($urandom);
        case ($urandom % 12)
            0, 1, 2, 3: return {OP_SPECIAL, pickReg(), pickReg(), pickReg(), 5'd0,
                                regFunctions[4'($urandom)]};
            4: return {OP_SPECIAL, 5'd0, pickReg(), pickReg(), sa,
                       shiftFunctions[2'($urandom % 3)]};
            5, 6, 7: begin
                op = immOpcodes[3'($urandom)];
                return {op, (op == OP_LUI) ? 5'd0 : pickReg(), pickReg(), imm};
            end
            8: begin
                op = branchOpcodes[3'($urandom % 5)];
                if (op == OP_BLEZ || op == OP_BGTZ) begin
                    return {op, pickReg(), 5'd0, imm};
                end
                if (op == OP_REGIMM) begin
                    return {op, pickReg(), 4'd0, 1'($urandom), imm};
                end
                return {op, pickReg(), pickReg(), imm};
            end
            9: return {OP_SPECIAL, 20'($urandom), ($urandom % 2) ? FN_SYSCALL : FN_BREAK};
            // Mostly reserved opcodes and functions
            10: return {6'($urandom), pickReg(), pickReg(), pickReg(), sa, 6'($urandom)};
            default: return $urandom;
        endcase
    endfunction

    // Model runs in program order at the input handshake
    always @(posedge clk) begin
        if (rstN) begin
            if (resValid && resReady) begin
                doneCount++;
                if (resultQueue.size() > 0) begin
                    void'(resultQueue.pop_front());
                end
            end
            if (instValid && instReady) begin
                resultQueue.push_back(predictResult(inst));
                acceptCount++;
            end
        end
    end

    // Head changes away from the rising edge
    always @(negedge clk) begin
        headValid = resultQueue.size() > 0;
        if (headValid) begin
            head = resultQueue[0];
        end
    end

    resultExpected: assert property (@(posedge clk) disable iff (!rstN)
        resValid && resReady |-> headValid)
        else failRun("a result left the DUT with no instruction outstanding");

    writeChecked: assert property (@(posedge clk) disable iff (!rstN)
        resValid && resReady && headValid |-> resWrite == head.write)
        else reportMismatch("resWrite", wordT'(head.write), wordT'($sampled(resWrite)));

    dstChecked: assert property (@(posedge clk) disable iff (!rstN)
        resValid && resReady && headValid && head.write |-> resDst == head.dst)
        else reportMismatch("resDst", wordT'(head.dst), wordT'($sampled(resDst)));

    dataChecked: assert property (@(posedge clk) disable iff (!rstN)
        resValid && resReady && headValid && head.write |-> resData == head.data)
        else reportMismatch("resData", head.data, $sampled(resData));

    branchChecked: assert property (@(posedge clk) disable iff (!rstN)
        resValid && resReady && headValid |-> resBranch == head.branch)
        else reportMismatch("resBranch", wordT'(head.branch), wordT'($sampled(resBranch)));

    takenChecked: assert property (@(posedge clk) disable iff (!rstN)
        resValid && resReady && headValid |-> resTaken == head.taken)
        else reportMismatch("resTaken", wordT'(head.taken), wordT'($sampled(resTaken)));

    excChecked: assert property (@(posedge clk) disable iff (!rstN)
        resValid && resReady && headValid |-> resExc == head.exc)
        else reportMismatch("resExc", wordT'(head.exc), wordT'($sampled(resExc)));

    excCodeChecked: assert property (@(posedge clk) disable iff (!rstN)
        resValid && resReady && headValid |-> resExcCode == head.excCode)
        else reportMismatch("resExcCode", wordT'(head.excCode), wordT'($sampled(resExcCode)));

    stallHolds: assert property (@(posedge clk) disable iff (!rstN)
        resValid && !resReady |=> resValid && $stable(resWrite) && $stable(resDst)
            && $stable(resData) && $stable(resBranch) && $stable(resTaken)
            && $stable(resExc) && $stable(resExcCode))
        else failRun("result fields changed while the output was stalled");

    initial begin
        int waitCycles;
        void'($urandom(32'h33c95c70));
        rstN = 1'b0;
        instValid = 1'b0;
        inst = '0;
        resReady = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        waitCycles = 0;
        while (acceptCount < numInsts) begin
            @(negedge clk);
            resReady = ($urandom % 4) != 0;
            if (instValid && issued != acceptCount) begin
                waitCycles++;
                if (waitCycles > 100) begin
                    failRun("input handshake timed out");
                end
            end else begin
                waitCycles = 0;
                if (issued < numInsts && ($urandom % 8) != 0) begin
                    instValid = 1'b1;
                    inst = randomInst();
                    issued++;
                end else begin
                    instValid = 1'b0;
                end
            end
        end
        // Drain with back-pressure still active
        waitCycles = 0;
        while (doneCount < numInsts && waitCycles < 200) begin
            @(negedge clk);
            resReady = ($urandom % 4) != 0;
            waitCycles++;
        end
        if (doneCount == numInsts && resultQueue.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            failRun("results did not drain before the timeout");
        end
    end

endmodule

//--- mipsSlice.f
+incdir+dv
source/mipsPkg.sv
source/decodeIf.sv
source/controlUnit.sv
source/regFile.sv
source/aluUnit.sv
source/execStage.sv
source/mipsSlice.sv
dv/mipsSliceTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mipsSliceTb
FILELIST = mipsSlice.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
